//--- tb.f
+incdir+rtl
rtl/versat_lite_pkg.sv
rtl/engine_conf_if.sv
rtl/conf_bank.sv
rtl/alu_lite.sv
rtl/data_engine.sv
rtl/versat_lite_top.sv
testbench/versat_lite_asserts.sv
testbench/tb_versat_lite.sv

//--- Makefile
# Verilator simulation of the versat_lite testbench

VERILATOR ?= verilator
TOP       ?= tb_versat_lite
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps
PASS_TEXT ?= ** PASS **

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/tb_versat_lite.sv
`timescale 1ns/1ps
`include "versat_lite_params.svh"

module tb_versat_lite;

	localparam int N_ROWS = 14;
	localparam int ROW_SETUP = 4;
	localparam int IDLE_CYCLES = 4;
	localparam int MARGIN = 50;

	logic                       clk;
	logic                       rst;
	logic                       conf_we;
	logic [`VL_CONF_ADDR_W-1:0] conf_addr;
	logic [`VL_DATA_W-1:0]      conf_wdata;
	logic                       conf_update;
	logic [`VL_DATA_W-1:0]      in_a;
	logic [`VL_DATA_W-1:0]      in_b;
	logic [`VL_DATA_W-1:0]      flow_out;

	versat_lite_top DUT (
		.clk         (clk),
		.rst         (rst),
		.conf_we     (conf_we),
		.conf_addr   (conf_addr),
		.conf_wdata  (conf_wdata),
		.conf_update (conf_update),
		.in_a        (in_a),
		.in_b        (in_b),
		.flow_out    (flow_out)
	);

	// test table
	string       row_name [N_ROWS];
	logic [31:0] row_alu0 [N_ROWS];
	logic [31:0] row_alu1 [N_ROWS];
	logic [31:0] row_out [N_ROWS];
	int          row_len [N_ROWS];
	int          row_mode [N_ROWS];
	logic        row_poke [N_ROWS];

	// reference state
	logic [31:0] m_shadow [3];
	logic [31:0] m_active [3];
	logic [31:0] m_a [2];
	logic [31:0] m_b [2];
	logic [31:0] m_res [2];

	logic [31:0] lfsr;
	int          cycle_cnt;
	int          cycle_limit;
	string       cur_test;

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("Timeout: the run went past %0d clock cycles", cycle_limit);
			$display("** FAIL **");
			$fatal(1, "cycle limit reached");
		end
	end

	// one step of the lfsr per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
		end
		return val;
	endfunction

	function automatic logic [31:0] corner_value(input logic [1:0] k);
		case (k)
			2'd0: return 32'h8000_0000;
			2'd1: return 32'h7fff_ffff;
			2'd2: return 32'h0000_0000;
			default: return 32'hffff_ffff;
		endcase
	endfunction

	// sela in bits 7:6, selb 5:4, self loop 3, function 2:0
	function automatic logic [31:0] alu_word(input logic [1:0] sela, input logic [1:0] selb,
			input logic loop, input versat_lite_pkg::alu_fn_t fn);
		return {24'd0, sela, selb, loop, fn};
	endfunction

	function automatic logic [31:0] out_word(input logic [1:0] sel, input logic run);
		return {23'd0, run, 6'd0, sel};
	endfunction

	// function table of one alu
	function automatic logic [31:0] alu_ref(input logic [7:0] cw, input logic [31:0] a_reg,
			input logic [31:0] b_reg, input logic [31:0] res);
		versat_lite_pkg::alu_fn_t fn;
		logic                     loop;
		logic                     hold;
		logic                     b_ge_a;
		logic [31:0]              a;
		logic [31:0]              diff;
		logic [31:0]              r;
		fn = versat_lite_pkg::alu_fn_t'(cw[2:0]);
		loop = cw[3];
		a = loop ? res : a_reg;
		hold = loop && a_reg[31];
		diff = b_reg - a;
		b_ge_a = $signed(b_reg) >= $signed(a);
		case (fn)
			versat_lite_pkg::FN_OR: r = a | b_reg;
			versat_lite_pkg::FN_AND: r = a & b_reg;
			versat_lite_pkg::FN_CMP_SIG: r = {($signed(b_reg) < $signed(a)), diff[30:0]};
			versat_lite_pkg::FN_MUX: r = a_reg[31] ? b_reg : (loop ? res : 32'd0);
			versat_lite_pkg::FN_SUB: r = diff;
			versat_lite_pkg::FN_ADD: r = hold ? b_reg : a + b_reg;
			versat_lite_pkg::FN_MAX: r = hold ? res : (b_ge_a ? b_reg : a);
			default: r = hold ? res : (b_ge_a ? a : b_reg);
		endcase
		return r;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < 3; i++) begin
			m_shadow[i] = '0;
			m_active[i] = '0;
		end
		for (int i = 0; i < 2; i++) begin
			m_a[i] = '0;
			m_b[i] = '0;
			m_res[i] = '0;
		end
	endtask

	// called right after a rising edge before any input moves
	task automatic model_edge();
		logic [31:0] bus [4];
		logic [31:0] nxt_res [2];
		logic [7:0]  cw;
		bus[0] = in_a;
		bus[1] = in_b;
		bus[2] = m_res[0];
		bus[3] = m_res[1];
		if (m_active[2][8]) begin
			for (int i = 0; i < 2; i++) begin
				cw = m_active[i][7:0];
				nxt_res[i] = alu_ref(cw, m_a[i], m_b[i], m_res[i]);
				m_a[i] = bus[cw[7:6]];
				m_b[i] = bus[cw[5:4]];
			end
			m_res[0] = nxt_res[0];
			m_res[1] = nxt_res[1];
		end
		if (conf_update) begin
			for (int i = 0; i < 3; i++) begin
				m_active[i] = m_shadow[i];
			end
		end
		if (conf_we && conf_addr <= `VL_ADDR_OUT) begin
			m_shadow[conf_addr] = conf_wdata;
		end
	endtask

	function automatic logic [31:0] model_out();
		case (m_active[2][1:0])
			2'd0: return in_a;
			2'd1: return in_b;
			2'd2: return m_res[0];
			default: return m_res[1];
		endcase
	endfunction

	task automatic check_value(input string test, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("Error: test %s expected %h actual %h", test, exp, act);
			$display("** FAIL **");
			$fatal(1, "flow_out mismatch");
		end
	endtask

	// mode 0 random, 1 corners and equal pairs, 2 accumulator stream
	task automatic make_inputs(input int mode);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] t;
		logic [2:0]  pick;
		a = take_bits(32);
		b = take_bits(32);
		pick = 3'(take_bits(3));
		if (mode == 1) begin
			case (pick)
				3'd0: a = corner_value(2'(take_bits(2)));
				3'd1: b = corner_value(2'(take_bits(2)));
				3'd2: b = a;
				3'd3: begin
					a = corner_value(2'(take_bits(2)));
					b = corner_value(2'(take_bits(2)));
				end
				3'd4: b = a + 32'd1;
				default: begin
				end
			endcase
		end else if (mode == 2) begin
			// a negative A word about one time in eight
			a = (pick == 3'd0) ? {1'b1, a[30:0]} : {24'd0, a[7:0]};
			t = take_bits(16);
			b = {{16{t[15]}}, t[15:0]};
		end
		in_a = a;
		in_b = b;
	endtask

	task automatic step(input logic we, input logic [1:0] addr, input logic [31:0] wdata,
			input logic upd, input int mode);
		@(posedge clk);
		model_edge();
		#2;
		conf_we = we;
		conf_addr = addr;
		conf_wdata = wdata;
		conf_update = upd;
		make_inputs(mode);
		@(negedge clk);
		check_value(cur_test, model_out(), flow_out);
	endtask

	task automatic run_row(input int r);
		int half;
		cur_test = row_name[r];
		half = row_len[r] / 2;
		step(1'b1, `VL_ADDR_ALU0, row_alu0[r], 1'b0, row_mode[r]);
		step(1'b1, `VL_ADDR_ALU1, row_alu1[r], 1'b0, row_mode[r]);
		step(1'b1, `VL_ADDR_OUT, row_out[r], 1'b0, row_mode[r]);
		step(1'b0, 2'd0, 32'd0, 1'b1, row_mode[r]);
		for (int v = 0; v < row_len[r]; v++) begin
			if (row_poke[r] && v == half) begin
				step(1'b1, `VL_ADDR_ALU1, alu_word(2'd2, 2'd0, 1'b0, versat_lite_pkg::FN_MAX),
					1'b0, row_mode[r]);
			end else if (row_poke[r] && v == half + 1) begin
				step(1'b1, 2'd3, 32'hffff_ffff, 1'b0, row_mode[r]);
			end else if (row_poke[r] && v == half + 2) begin
				step(1'b0, 2'd0, 32'd0, 1'b1, row_mode[r]);
			end else begin
				step(1'b0, 2'd0, 32'd0, 1'b0, row_mode[r]);
			end
		end
	endtask

	task automatic set_row(input int r, input string name, input logic [31:0] w0,
			input logic [31:0] w1, input logic [31:0] wo, input int len, input int mode,
			input logic poke);
		row_name[r] = name;
		row_alu0[r] = w0;
		row_alu1[r] = w1;
		row_out[r] = wo;
		row_len[r] = len;
		row_mode[r] = mode;
		row_poke[r] = poke;
	endtask

	task automatic load_table();
		logic [31:0] w_or;
		logic [31:0] w_and;
		w_or = alu_word(2'd0, 2'd1, 1'b0, versat_lite_pkg::FN_OR);
		w_and = alu_word(2'd0, 2'd1, 1'b0, versat_lite_pkg::FN_AND);
		set_row(0, "reset_hold", alu_word(2'd0, 2'd1, 1'b0, versat_lite_pkg::FN_ADD), w_or,
			out_word(2'd2, 1'b0), 6, 0, 1'b0);
		set_row(1, "or", w_or, w_and, out_word(2'd2, 1'b1), 10, 1, 1'b0);
		set_row(2, "and", w_or, w_and, out_word(2'd3, 1'b1), 10, 1, 1'b0);
		set_row(3, "sub", alu_word(2'd0, 2'd1, 1'b0, versat_lite_pkg::FN_SUB),
			alu_word(2'd0, 2'd1, 1'b0, versat_lite_pkg::FN_CMP_SIG), out_word(2'd2, 1'b1),
			12, 1, 1'b0);
		set_row(4, "cmp_sig", row_alu0[3], row_alu1[3], out_word(2'd3, 1'b1), 12, 1, 1'b0);
		set_row(5, "max", alu_word(2'd0, 2'd1, 1'b0, versat_lite_pkg::FN_MAX),
			alu_word(2'd0, 2'd1, 1'b0, versat_lite_pkg::FN_MIN), out_word(2'd2, 1'b1),
			14, 1, 1'b0);
		set_row(6, "min", row_alu0[5], row_alu1[5], out_word(2'd3, 1'b1), 14, 1, 1'b0);
		set_row(7, "acc_add", alu_word(2'd0, 2'd1, 1'b1, versat_lite_pkg::FN_ADD),
			alu_word(2'd0, 2'd1, 1'b1, versat_lite_pkg::FN_MAX), out_word(2'd2, 1'b1),
			20, 2, 1'b0);
		set_row(8, "run_max", row_alu0[7], row_alu1[7], out_word(2'd3, 1'b1), 20, 2, 1'b0);
		set_row(9, "run_min", alu_word(2'd0, 2'd1, 1'b1, versat_lite_pkg::FN_MIN),
			alu_word(2'd0, 2'd1, 1'b0, versat_lite_pkg::FN_MUX), out_word(2'd2, 1'b1),
			20, 2, 1'b0);
		set_row(10, "mux_pass", row_alu0[9], row_alu1[9], out_word(2'd3, 1'b1), 16, 2, 1'b0);
		set_row(11, "mux_hold", alu_word(2'd0, 2'd1, 1'b1, versat_lite_pkg::FN_MUX),
			alu_word(2'd0, 2'd1, 1'b0, versat_lite_pkg::FN_ADD), out_word(2'd2, 1'b1),
			16, 2, 1'b0);
		// alu0 result feeds alu1 operand A
		set_row(12, "chain", alu_word(2'd0, 2'd1, 1'b0, versat_lite_pkg::FN_SUB),
			alu_word(2'd2, 2'd1, 1'b0, versat_lite_pkg::FN_ADD), out_word(2'd3, 1'b1),
			16, 1, 1'b1);
		set_row(13, "in_b_direct", w_or, w_and, out_word(2'd1, 1'b1), 6, 0, 1'b0);
	endtask

	initial begin
		int total;
		clk = 1'b0;
		rst = 1'b1;
		conf_we = 1'b0;
		conf_addr = '0;
		conf_wdata = '0;
		conf_update = 1'b0;
		in_a = '0;
		in_b = '0;
		lfsr = 32'h4dea;
		cycle_cnt = 0;
		cycle_limit = 0;
		model_reset();
		load_table();
		total = 2 + IDLE_CYCLES + MARGIN;
		for (int r = 0; r < N_ROWS; r++) begin
			total = total + ROW_SETUP + row_len[r];
		end
		cycle_limit = total;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		// flow_out follows in_a while out_sel is still 0
		cur_test = "after_reset";
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			step(1'b0, 2'd0, 32'd0, 1'b0, 0);
		end
		for (int r = 0; r < N_ROWS; r++) begin
			run_row(r);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

//--- testbench/versat_lite_asserts.sv
`timescale 1ns/1ps
`include "versat_lite_params.svh"

module versat_lite_asserts (
	input logic                  clk,
	input logic                  rst,
	input logic                  commit,
	input logic                  run_lvl,
	input logic [`VL_DATA_W-1:0] watched
);

	// register may only move on an edge with commit high
	hold_without_commit: assert property (@(posedge clk) disable iff (rst)
		!commit |=> $stable(watched))
		else $error("watched register changed on an edge without commit");

	reset_clears: assert property (@(posedge clk)
		rst |=> watched == '0)
		else $error("watched register not zero after reset");

	// nothing runs until the first committed setup
	idle_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> !run_lvl)
		else $error("run was high right after reset");

endmodule

// active setup of the bank, committed by conf_update
bind conf_bank versat_lite_asserts bank_checks (
	.clk     (clk),
	.rst     (rst),
	.commit  (conf_update),
	.run_lvl (conf.run),
	.watched ({13'd0, conf.alu_conf, conf.out_sel, conf.run})
);

bind alu_lite versat_lite_asserts alu_checks (
	.clk     (clk),
	.rst     (rst),
	.commit  (run),
	.run_lvl (run),
	.watched (result)
);

//--- rtl/versat_lite_top.sv
`timescale 1ns/1ps
`include "versat_lite_params.svh"

module versat_lite_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       conf_we,
	input  logic [`VL_CONF_ADDR_W-1:0] conf_addr,
	input  logic [`VL_DATA_W-1:0]      conf_wdata,
	input  logic                       conf_update,
	input  logic [`VL_DATA_W-1:0]      in_a,
	input  logic [`VL_DATA_W-1:0]      in_b,
	output logic [`VL_DATA_W-1:0]      flow_out
);

	engine_conf_if eng_conf ();

	conf_bank bank (
		.clk         (clk),
		.rst         (rst),
		.conf_we     (conf_we),
		.conf_addr   (conf_addr),
		.conf_wdata  (conf_wdata),
		.conf_update (conf_update),
		.conf        (eng_conf.bank)
	);

	data_engine engine (
		.clk      (clk),
		.rst      (rst),
		.in_a     (in_a),
		.in_b     (in_b),
		.conf     (eng_conf.engine),
		.flow_out (flow_out)
	);

endmodule

//--- rtl/data_engine.sv
`timescale 1ns/1ps
`include "versat_lite_params.svh"

module data_engine (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`VL_DATA_W-1:0] in_a,
	input  logic [`VL_DATA_W-1:0] in_b,
	engine_conf_if.engine         conf,
	output logic [`VL_DATA_W-1:0] flow_out
);

	versat_lite_pkg::flow_bus_t flow_bus;
	logic [`VL_DATA_W-1:0]      alu0_res;
	logic [`VL_DATA_W-1:0]      alu1_res;

	// slot order fixed by the bus definition
	assign flow_bus[0] = in_a;
	assign flow_bus[1] = in_b;
	assign flow_bus[2] = alu0_res;
	assign flow_bus[3] = alu1_res;

	alu_lite #(
		.DATA_W (`VL_DATA_W)
	) alu0 (
		.clk     (clk),
		.rst     (rst),
		.flow_in (flow_bus),
		.conf    (conf.alu_conf[0]),
		.run     (conf.run),
		.result  (alu0_res)
	);

	alu_lite #(
		.DATA_W (`VL_DATA_W)
	) alu1 (
		.clk     (clk),
		.rst     (rst),
		.flow_in (flow_bus),
		.conf    (conf.alu_conf[1]),
		.run     (conf.run),
		.result  (alu1_res)
	);

	// no register here, inputs reach the output the same cycle
	assign flow_out = flow_bus[conf.out_sel];

endmodule

//--- rtl/alu_lite.sv
`timescale 1ns/1ps
`include "versat_lite_params.svh"

module alu_lite #(
	parameter int DATA_W = `VL_DATA_W
) (
	input  logic                       clk,
	input  logic                       rst,
	input  versat_lite_pkg::flow_bus_t flow_in,
	input  versat_lite_pkg::alu_conf_t conf,
	input  logic                       run,
	output logic [DATA_W-1:0]          result
);

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] op_a_reg;
	logic [DATA_W-1:0] op_b_reg;
	logic [DATA_W-1:0] op_a_int;
	logic              a_neg;
	logic              invert_a;
	logic              a_msb;
	logic              b_msb;
	logic [DATA_W:0]   a_term;
	logic [DATA_W:0]   adder;
	logic              borrow;
	logic [DATA_W-1:0] result_nxt;

	// operand pick straight off the bus
	assign op_a = flow_in[conf.sela];
	assign op_b = flow_in[conf.selb];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			op_a_reg <= '0;
			op_b_reg <= '0;
		end else if (run) begin
			op_a_reg <= op_a;
			op_b_reg <= op_b;
		end
	end

	// self loop replaces A with the last result
	assign op_a_int = conf.self_loop ? result : op_a_reg;
	assign a_neg = op_a_reg[DATA_W-1];

	// one shared adder, A inverted for the subtracting functions
	always_comb begin
		invert_a = 1'b0;
		a_msb    = 1'b0;
		b_msb    = 1'b0;
		case (conf.fns)
			versat_lite_pkg::FN_SUB: begin
				invert_a = 1'b1;
			end
			versat_lite_pkg::FN_CMP_SIG,
			versat_lite_pkg::FN_MAX,
			versat_lite_pkg::FN_MIN: begin
				invert_a = 1'b1;
				a_msb    = op_a_int[DATA_W-1];
				b_msb    = op_b_reg[DATA_W-1];
			end
			default: begin
			end
		endcase
	end

	assign a_term = {a_msb, op_a_int} ^ {(DATA_W + 1){invert_a}};
	assign adder  = {b_msb, op_b_reg} + a_term + {{DATA_W{1'b0}}, invert_a};
	// set when B < A, signed
	assign borrow = adder[DATA_W];

	always_comb begin
		result_nxt = adder[DATA_W-1:0];
		case (conf.fns)
			versat_lite_pkg::FN_OR: begin
				result_nxt = op_a_int | op_b_reg;
			end
			versat_lite_pkg::FN_AND: begin
				result_nxt = op_a_int & op_b_reg;
			end
			versat_lite_pkg::FN_CMP_SIG: begin
				result_nxt[DATA_W-1] = borrow;
			end
			versat_lite_pkg::FN_MUX: begin
				if (a_neg) begin
					result_nxt = op_b_reg;
				end else if (conf.self_loop) begin
					result_nxt = result;
				end else begin
					result_nxt = '0;
				end
			end
			versat_lite_pkg::FN_SUB: begin
				result_nxt = adder[DATA_W-1:0];
			end
			versat_lite_pkg::FN_ADD: begin
				// negative A word restarts the accumulator
				if (conf.self_loop && a_neg) begin
					result_nxt = op_b_reg;
				end
			end
			versat_lite_pkg::FN_MAX: begin
				result_nxt = borrow ? op_a_int : op_b_reg;
				if (conf.self_loop && a_neg) begin
					result_nxt = result;
				end
			end
			versat_lite_pkg::FN_MIN: begin
				result_nxt = borrow ? op_b_reg : op_a_int;
				if (conf.self_loop && a_neg) begin
					result_nxt = result;
				end
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			result <= '0;
		end else if (run) begin
			result <= result_nxt;
		end
	end

endmodule

//--- rtl/conf_bank.sv
`timescale 1ns/1ps
`include "versat_lite_params.svh"

module conf_bank (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       conf_we,
	input  logic [`VL_CONF_ADDR_W-1:0] conf_addr,
	input  logic [`VL_DATA_W-1:0]      conf_wdata,
	input  logic                       conf_update,
	engine_conf_if.bank                conf
);

	localparam int ALU_CONF_W = $bits(versat_lite_pkg::alu_conf_t);
	localparam int RUN_BIT = 8;

	versat_lite_pkg::alu_conf_t [1:0] shadow_alu;
	logic [`VL_N_W-1:0]               shadow_out_sel;
	logic                             shadow_run;

	// shadow words, one write per strobe
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			shadow_alu     <= '0;
			shadow_out_sel <= '0;
			shadow_run     <= 1'b0;
		end else if (conf_we) begin
			case (conf_addr)
				`VL_ADDR_ALU0: begin
					shadow_alu[0] <= versat_lite_pkg::alu_conf_t'(conf_wdata[ALU_CONF_W-1:0]);
				end
				`VL_ADDR_ALU1: begin
					shadow_alu[1] <= versat_lite_pkg::alu_conf_t'(conf_wdata[ALU_CONF_W-1:0]);
				end
				`VL_ADDR_OUT: begin
					shadow_out_sel <= conf_wdata[`VL_N_W-1:0];
					shadow_run     <= conf_wdata[RUN_BIT];
				end
				default: begin
				end
			endcase
		end
	end

	// whole setup switches on one edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			conf.alu_conf <= '0;
			conf.out_sel  <= '0;
			conf.run      <= 1'b0;
		end else if (conf_update) begin
			conf.alu_conf <= shadow_alu;
			conf.out_sel  <= shadow_out_sel;
			conf.run      <= shadow_run;
		end
	end

endmodule

//--- rtl/engine_conf_if.sv
`timescale 1ns/1ps
`include "versat_lite_params.svh"

interface engine_conf_if;

	// active setup, one entry per alu
	versat_lite_pkg::alu_conf_t [1:0] alu_conf;
	logic [`VL_N_W-1:0]               out_sel;
	// low freezes both alus
	logic                             run;

	modport bank (
		output alu_conf,
		output out_sel,
		output run
	);

	modport engine (
		input alu_conf,
		input out_sel,
		input run
	);

endinterface

//--- rtl/versat_lite_pkg.sv
`include "versat_lite_params.svh"

package versat_lite_pkg;

	// alu function codes
	typedef enum logic [2:0] {
		FN_OR      = 3'd0,
		FN_AND     = 3'd1,
		FN_CMP_SIG = 3'd2,
		FN_MUX     = 3'd3,
		FN_SUB     = 3'd4,
		FN_ADD     = 3'd5,
		FN_MAX     = 3'd6,
		FN_MIN     = 3'd7
	} alu_fn_t;

	// low byte of an alu configuration word
	typedef struct packed {
		logic [`VL_N_W-1:0] sela;
		logic [`VL_N_W-1:0] selb;
		logic               self_loop;
		alu_fn_t            fns;
	} alu_conf_t;

	// slot 0 is in_a, slot 3 is alu1
	typedef logic [`VL_N_SLOTS-1:0][`VL_DATA_W-1:0] flow_bus_t;

endpackage

//--- rtl/versat_lite_params.svh
`ifndef VERSAT_LITE_PARAMS_SVH
`define VERSAT_LITE_PARAMS_SVH

// datapath word
`define VL_DATA_W 32

// flow bus: in_a, in_b, alu0, alu1
`define VL_N_SLOTS 4
`define VL_N_W 2

// configuration space
`define VL_CONF_ADDR_W 2
`define VL_ADDR_ALU0 2'd0
`define VL_ADDR_ALU1 2'd1
`define VL_ADDR_OUT 2'd2

// address 3 is reserved

`endif
